// File: include/upif_settings.svh
// Widths, queue depth, pacing and block size of the upload front end.
// UPIF_REQ_DEPTH bounds the outstanding requests, since the queue has no full flag.
// UPIF_BLK_BYTES must be a power of two that UPIF_OFS_W bits can wrap.
`ifndef UPIF_SETTINGS_SVH
`define UPIF_SETTINGS_SVH

// ============================================================
// field widths
// ============================================================
`define UPIF_VCH_W      16          // virtual channel
`define UPIF_ADDR_W     32          // file address
`define UPIF_SIZE_W     32          // file size in bytes
`define UPIF_DATA_W     64          // one DMA beat

// ============================================================
// block segmentation
// ============================================================
`define UPIF_BEAT_BYTES 8
`define UPIF_BLK_BYTES  4096        // 4 KiB blocks
`define UPIF_OFS_W      12          // in-block byte offset
`define UPIF_BSZ_W      16          // block byte count field

// ============================================================
// request queue
// ============================================================
`define UPIF_REQ_W      (`UPIF_VCH_W + `UPIF_ADDR_W + `UPIF_SIZE_W)
`define UPIF_REQ_DEPTH  16
`define UPIF_RD_PACE    8           // min cycles between released requests

`endif

// File: design/upif_req_pkg.sv
// Request word layout is {vch, addr, size}, with vch in the top bits.
`include "upif_settings.svh"

package upif_req_pkg;

    function automatic logic [`UPIF_REQ_W-1:0] pack_req(
        input logic [`UPIF_VCH_W-1:0]  vch,
        input logic [`UPIF_ADDR_W-1:0] addr,
        input logic [`UPIF_SIZE_W-1:0] size
    );
        return {vch, addr, size};
    endfunction

    function automatic logic [`UPIF_VCH_W-1:0] req_vch(input logic [`UPIF_REQ_W-1:0] word);
        return word[`UPIF_REQ_W-1 -: `UPIF_VCH_W];
    endfunction

    function automatic logic [`UPIF_ADDR_W-1:0] req_addr(input logic [`UPIF_REQ_W-1:0] word);
        return word[`UPIF_SIZE_W +: `UPIF_ADDR_W];          // sits just above size
    endfunction

    function automatic logic [`UPIF_SIZE_W-1:0] req_size(input logic [`UPIF_REQ_W-1:0] word);
        return word[`UPIF_SIZE_W-1:0];
    endfunction

endpackage

// File: design/upif_stream_pkg.sv
// Offsets are byte offsets of a beat within its 4 KiB block.
// Beats are whole UPIF_BEAT_BYTES words, so offsets stay beat aligned.
`include "upif_settings.svh"

package upif_stream_pkg;

    function automatic logic is_blk_first(input logic [`UPIF_OFS_W-1:0] ofs);
        return (ofs == '0);
    endfunction

    function automatic logic is_blk_last(input logic [`UPIF_OFS_W-1:0] ofs);
        return (ofs == `UPIF_OFS_W'(`UPIF_BLK_BYTES - `UPIF_BEAT_BYTES));
    endfunction

    // bytes in a block whose last beat sits at ofs
    function automatic logic [`UPIF_BSZ_W-1:0] blk_bytes(input logic [`UPIF_OFS_W-1:0] ofs);
        logic [`UPIF_BSZ_W-1:0] cnt;
        cnt = `UPIF_BSZ_W'(ofs) + `UPIF_BSZ_W'(`UPIF_BEAT_BYTES);
        return cnt;
    endfunction

endpackage

// File: design/upif_req_queue.sv
// Request FIFO without a full flag. The sender keeps at most UPIF_REQ_DEPTH pending.
// q_word is registered and valid on the cycle after q_pop.
`timescale 1ns/1ns
`include "upif_settings.svh"

module upif_req_queue (
    input  logic                     USER_CLK,
    input  logic                     USER_RST,
    input  logic                     up_file_sof,
    input  logic [`UPIF_VCH_W-1:0]   up_file_vch,
    input  logic [`UPIF_ADDR_W-1:0]  up_file_addr,
    input  logic [`UPIF_SIZE_W-1:0]  up_file_size,
    input  logic                     q_pop,
    output logic [`UPIF_REQ_W-1:0]   q_word,
    output logic                     q_empty
);

    logic                                 req_wen;  // captured request pending write
    logic [`UPIF_REQ_W-1:0]               req_wdt;
    logic [`UPIF_REQ_W-1:0]               mem [`UPIF_REQ_DEPTH];
    logic [$clog2(`UPIF_REQ_DEPTH):0]     wr_ptr;   // extra msb tells full from empty
    logic [$clog2(`UPIF_REQ_DEPTH):0]     rd_ptr;

    // ============================================================
    // request capture
    // ============================================================
    always_ff @(posedge USER_CLK or posedge USER_RST) begin
        if (USER_RST) begin
            req_wen <= 1'b0;
        end else begin
            req_wen <= up_file_sof;
        end
    end

    always_ff @(posedge USER_CLK) begin
        if (up_file_sof) begin
            req_wdt <= upif_req_pkg::pack_req(up_file_vch, up_file_addr, up_file_size);
        end
    end

    // ============================================================
    // circular buffer
    // ============================================================
    always_ff @(posedge USER_CLK or posedge USER_RST) begin
        if (USER_RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (req_wen) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (q_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge USER_CLK) begin
        if (req_wen) begin
            mem[wr_ptr[$clog2(`UPIF_REQ_DEPTH)-1:0]] <= req_wdt;
        end
    end

    always_ff @(posedge USER_CLK) begin
        if (q_pop) begin
            q_word <= mem[rd_ptr[$clog2(`UPIF_REQ_DEPTH)-1:0]];  // registered read
        end
    end

    assign q_empty = (wr_ptr == rd_ptr);

endmodule

// File: design/upif_req_dispatch.sv
// Releases queued requests no closer than UPIF_RD_PACE cycles apart, oldest first.
// The read engine gives no back-pressure. dma_rd_* hold until the next dma_rd_start.
`timescale 1ns/1ns
`include "upif_settings.svh"

module upif_req_dispatch (
    input  logic                     USER_CLK,
    input  logic                     USER_RST,
    input  logic [`UPIF_REQ_W-1:0]   q_word,
    input  logic                     q_empty,
    output logic                     q_pop,
    output logic                     dma_rd_start,
    output logic [`UPIF_VCH_W-1:0]   dma_rd_vch,
    output logic [`UPIF_ADDR_W-1:0]  dma_rd_addr,
    output logic [`UPIF_SIZE_W-1:0]  dma_rd_size
);

    logic                       q_rdy;      // queue was not empty at last edge
    logic [`UPIF_RD_PACE-1:0]   pace_tok;   // one-hot pace ring
    logic                       word_vld;   // popped word now on q_word

    // ============================================================
    // pacing and pop
    // ============================================================
    always_ff @(posedge USER_CLK or posedge USER_RST) begin
        if (USER_RST) begin
            q_rdy    <= 1'b0;
            pace_tok <= `UPIF_RD_PACE'(1);
        end else begin
            q_rdy    <= ~q_empty;
            pace_tok <= {pace_tok[0], pace_tok[`UPIF_RD_PACE-1:1]};  // rotate right
        end
    end

    // one pop per ring turn keeps the lagging q_rdy safe
    always_ff @(posedge USER_CLK or posedge USER_RST) begin
        if (USER_RST) begin
            q_pop    <= 1'b0;
            word_vld <= 1'b0;
        end else begin
            q_pop    <= q_rdy & pace_tok[0];
            word_vld <= q_pop;
        end
    end

    // ============================================================
    // read command
    // ============================================================
    always_ff @(posedge USER_CLK or posedge USER_RST) begin
        if (USER_RST) begin
            dma_rd_start <= 1'b0;
        end else begin
            dma_rd_start <= word_vld;
        end
    end

    always_ff @(posedge USER_CLK) begin
        if (word_vld) begin
            dma_rd_vch  <= upif_req_pkg::req_vch(q_word);
            dma_rd_addr <= upif_req_pkg::req_addr(q_word);
            dma_rd_size <= upif_req_pkg::req_size(q_word);
        end
    end

endmodule

// File: design/upif_block_seg.sv
// Cuts a beat stream into 4 KiB blocks by byte offset. The offset restarts at sof.
// Inputs come from the first pipeline stage, outputs line up with the second.
`timescale 1ns/1ns
`include "upif_settings.svh"

module upif_block_seg (
    input  logic                     USER_CLK,
    input  logic                     USER_RST,
    input  logic                     beat_vld,
    input  logic                     beat_sof,
    input  logic                     beat_eof,
    output logic                     blk_sob,
    output logic                     blk_eob,
    output logic [`UPIF_BSZ_W-1:0]   blk_bsz
);

    logic [`UPIF_OFS_W-1:0]  ofs_cnt;   // offset of the next beat
    logic [`UPIF_OFS_W-1:0]  cur_ofs;   // offset of the beat at hand
    logic                    sob_hit;
    logic                    eob_hit;

    assign cur_ofs = beat_sof ? '0 : ofs_cnt;

    assign sob_hit = beat_vld & (beat_sof | upif_stream_pkg::is_blk_first(cur_ofs));
    assign eob_hit = beat_vld & (beat_eof | upif_stream_pkg::is_blk_last(cur_ofs));

    // ============================================================
    // offset counter
    // ============================================================
    always_ff @(posedge USER_CLK or posedge USER_RST) begin
        if (USER_RST) begin
            ofs_cnt <= '0;
        end else if (beat_vld) begin
            ofs_cnt <= cur_ofs + `UPIF_OFS_W'(`UPIF_BEAT_BYTES);  // wraps at 4 KiB
        end
    end

    // ============================================================
    // block marks and size
    // ============================================================
    always_ff @(posedge USER_CLK or posedge USER_RST) begin
        if (USER_RST) begin
            blk_sob <= 1'b0;
            blk_eob <= 1'b0;
        end else begin
            blk_sob <= sob_hit;
            blk_eob <= eob_hit;
        end
    end

    // full block gives 4096, a short tail its own count
    always_ff @(posedge USER_CLK or posedge USER_RST) begin
        if (USER_RST) begin
            blk_bsz <= '0;
        end else if (eob_hit) begin
            blk_bsz <= upif_stream_pkg::blk_bytes(cur_ofs);
        end
    end

endmodule

// File: design/upif_upload_path.sv
// Two register stages from the DMA beat stream to the line-buffer writer; never stalls.
// dma_up_rdy lags up_lbuf_wr_rdy by one cycle, so the source must stop within 2 cycles.
`timescale 1ns/1ns
`include "upif_settings.svh"

module upif_upload_path (
    input  logic                     USER_CLK,
    input  logic                     USER_RST,
    input  logic                     dma_up_dvld,
    input  logic [`UPIF_DATA_W-1:0]  dma_up_data,
    input  logic                     dma_up_sof,
    input  logic                     dma_up_eof,
    input  logic [`UPIF_VCH_W-1:0]   dma_up_vch,
    input  logic [`UPIF_ADDR_W-1:0]  dma_up_addr,
    input  logic [`UPIF_SIZE_W-1:0]  dma_up_size,
    output logic                     dma_up_rdy,
    input  logic                     up_lbuf_wr_rdy,
    output logic [`UPIF_DATA_W-1:0]  up_lbuf_wr_data,
    output logic                     up_lbuf_wr_dvld,
    output logic                     up_lbuf_wr_sof,
    output logic                     up_lbuf_wr_eof,
    output logic [`UPIF_VCH_W-1:0]   up_lbuf_wr_vch,
    output logic [`UPIF_ADDR_W-1:0]  up_lbuf_wr_addr,
    output logic [`UPIF_SIZE_W-1:0]  up_lbuf_wr_fsz,
    output logic                     up_lbuf_wr_sob,
    output logic                     up_lbuf_wr_eob,
    output logic [`UPIF_BSZ_W-1:0]   up_lbuf_wr_bsz
);

    logic [`UPIF_DATA_W-1:0]  s1_data;
    logic                     s1_dvld;
    logic                     s1_sof;
    logic                     s1_eof;
    logic [`UPIF_VCH_W-1:0]   s1_vch;   // held from the file's sof
    logic [`UPIF_ADDR_W-1:0]  s1_addr;
    logic [`UPIF_SIZE_W-1:0]  s1_size;  // held from eof

    always_ff @(posedge USER_CLK or posedge USER_RST) begin
        if (USER_RST) begin
            dma_up_rdy <= 1'b1;
        end else begin
            dma_up_rdy <= up_lbuf_wr_rdy;
        end
    end

    // ============================================================
    // stage 1
    // ============================================================
    always_ff @(posedge USER_CLK or posedge USER_RST) begin
        if (USER_RST) begin
            s1_dvld <= 1'b0;
            s1_sof  <= 1'b0;
            s1_eof  <= 1'b0;
        end else begin
            s1_dvld <= dma_up_dvld;
            s1_sof  <= dma_up_sof;
            s1_eof  <= dma_up_eof;
        end
    end

    always_ff @(posedge USER_CLK) begin
        s1_data <= dma_up_data;
        if (dma_up_dvld & dma_up_sof) begin
            s1_vch  <= dma_up_vch;
            s1_addr <= dma_up_addr;
        end
        if (dma_up_dvld & dma_up_eof) begin
            s1_size <= dma_up_size;
        end
    end

    // ============================================================
    // stage 2
    // ============================================================
    always_ff @(posedge USER_CLK or posedge USER_RST) begin
        if (USER_RST) begin
            up_lbuf_wr_dvld <= 1'b0;
            up_lbuf_wr_sof  <= 1'b0;
            up_lbuf_wr_eof  <= 1'b0;
        end else begin
            up_lbuf_wr_dvld <= s1_dvld;
            up_lbuf_wr_sof  <= s1_sof;
            up_lbuf_wr_eof  <= s1_eof;
        end
    end

    always_ff @(posedge USER_CLK) begin
        up_lbuf_wr_data <= s1_data;
        up_lbuf_wr_vch  <= s1_vch;
        up_lbuf_wr_addr <= s1_addr;
        up_lbuf_wr_fsz  <= s1_size;
    end

    upif_block_seg i_block_seg (
        .USER_CLK (USER_CLK),
        .USER_RST (USER_RST),
        .beat_vld (s1_dvld),
        .beat_sof (s1_sof),
        .beat_eof (s1_eof),
        .blk_sob  (up_lbuf_wr_sob),
        .blk_eob  (up_lbuf_wr_eob),
        .blk_bsz  (up_lbuf_wr_bsz)
    );

endmodule

// File: design/upif_top.sv
// Upload-side front end of the DMA engine, all on USER_CLK.
// Request inputs are single-cycle pulses. Upload beats take exactly 2 cycles to the writer.
`timescale 1ns/1ns
`include "upif_settings.svh"

module upif_top (
    input  logic                     USER_CLK,
    input  logic                     USER_RST,
    // request path
    input  logic                     up_file_sof,
    input  logic [`UPIF_VCH_W-1:0]   up_file_vch,
    input  logic [`UPIF_ADDR_W-1:0]  up_file_addr,
    input  logic [`UPIF_SIZE_W-1:0]  up_file_size,
    output logic                     dma_rd_start,
    output logic [`UPIF_VCH_W-1:0]   dma_rd_vch,
    output logic [`UPIF_ADDR_W-1:0]  dma_rd_addr,
    output logic [`UPIF_SIZE_W-1:0]  dma_rd_size,
    // upload beats from the DMA
    input  logic                     dma_up_dvld,
    input  logic [`UPIF_DATA_W-1:0]  dma_up_data,
    input  logic                     dma_up_sof,
    input  logic                     dma_up_eof,
    input  logic [`UPIF_VCH_W-1:0]   dma_up_vch,
    input  logic [`UPIF_ADDR_W-1:0]  dma_up_addr,
    input  logic [`UPIF_SIZE_W-1:0]  dma_up_size,
    output logic                     dma_up_rdy,
    // line-buffer writer
    input  logic                     up_lbuf_wr_rdy,
    output logic [`UPIF_DATA_W-1:0]  up_lbuf_wr_data,
    output logic                     up_lbuf_wr_dvld,
    output logic                     up_lbuf_wr_sof,
    output logic                     up_lbuf_wr_eof,
    output logic [`UPIF_VCH_W-1:0]   up_lbuf_wr_vch,
    output logic [`UPIF_ADDR_W-1:0]  up_lbuf_wr_addr,
    output logic [`UPIF_SIZE_W-1:0]  up_lbuf_wr_fsz,
    output logic                     up_lbuf_wr_sob,
    output logic                     up_lbuf_wr_eob,
    output logic [`UPIF_BSZ_W-1:0]   up_lbuf_wr_bsz
);

    logic [`UPIF_REQ_W-1:0]  q_word;
    logic                    q_empty;
    logic                    q_pop;

    // ============================================================
    // request path
    // ============================================================
    upif_req_queue i_req_queue (
        .USER_CLK     (USER_CLK),
        .USER_RST     (USER_RST),
        .up_file_sof  (up_file_sof),
        .up_file_vch  (up_file_vch),
        .up_file_addr (up_file_addr),
        .up_file_size (up_file_size),
        .q_pop        (q_pop),
        .q_word       (q_word),
        .q_empty      (q_empty)
    );

    upif_req_dispatch i_req_dispatch (
        .USER_CLK     (USER_CLK),
        .USER_RST     (USER_RST),
        .q_word       (q_word),
        .q_empty      (q_empty),
        .q_pop        (q_pop),
        .dma_rd_start (dma_rd_start),
        .dma_rd_vch   (dma_rd_vch),
        .dma_rd_addr  (dma_rd_addr),
        .dma_rd_size  (dma_rd_size)
    );

    // ============================================================
    // upload path
    // ============================================================
    upif_upload_path i_upload_path (
        .USER_CLK        (USER_CLK),
        .USER_RST        (USER_RST),
        .dma_up_dvld     (dma_up_dvld),
        .dma_up_data     (dma_up_data),
        .dma_up_sof      (dma_up_sof),
        .dma_up_eof      (dma_up_eof),
        .dma_up_vch      (dma_up_vch),
        .dma_up_addr     (dma_up_addr),
        .dma_up_size     (dma_up_size),
        .dma_up_rdy      (dma_up_rdy),
        .up_lbuf_wr_rdy  (up_lbuf_wr_rdy),
        .up_lbuf_wr_data (up_lbuf_wr_data),
        .up_lbuf_wr_dvld (up_lbuf_wr_dvld),
        .up_lbuf_wr_sof  (up_lbuf_wr_sof),
        .up_lbuf_wr_eof  (up_lbuf_wr_eof),
        .up_lbuf_wr_vch  (up_lbuf_wr_vch),
        .up_lbuf_wr_addr (up_lbuf_wr_addr),
        .up_lbuf_wr_fsz  (up_lbuf_wr_fsz),
        .up_lbuf_wr_sob  (up_lbuf_wr_sob),
        .up_lbuf_wr_eob  (up_lbuf_wr_eob),
        .up_lbuf_wr_bsz  (up_lbuf_wr_bsz)
    );

endmodule

// File: dv/upif_props.sv
// Concurrent checks on the upif_top ports, bound into the DUT.
// Expected values come from the port inputs only. Needs assertions enabled in the simulator.
`timescale 1ns/1ns
`include "upif_settings.svh"

module upif_props (
    input logic                     USER_CLK,
    input logic                     USER_RST,
    input logic                     up_file_sof,
    input logic [`UPIF_VCH_W-1:0]   up_file_vch,
    input logic [`UPIF_ADDR_W-1:0]  up_file_addr,
    input logic [`UPIF_SIZE_W-1:0]  up_file_size,
    input logic                     dma_rd_start,
    input logic [`UPIF_VCH_W-1:0]   dma_rd_vch,
    input logic [`UPIF_ADDR_W-1:0]  dma_rd_addr,
    input logic [`UPIF_SIZE_W-1:0]  dma_rd_size,
    input logic                     dma_up_dvld,
    input logic [`UPIF_DATA_W-1:0]  dma_up_data,
    input logic                     dma_up_sof,
    input logic                     dma_up_eof,
    input logic [`UPIF_VCH_W-1:0]   dma_up_vch,
    input logic [`UPIF_ADDR_W-1:0]  dma_up_addr,
    input logic [`UPIF_SIZE_W-1:0]  dma_up_size,
    input logic                     dma_up_rdy,
    input logic                     up_lbuf_wr_rdy,
    input logic [`UPIF_DATA_W-1:0]  up_lbuf_wr_data,
    input logic                     up_lbuf_wr_dvld,
    input logic                     up_lbuf_wr_sof,
    input logic                     up_lbuf_wr_eof,
    input logic [`UPIF_VCH_W-1:0]   up_lbuf_wr_vch,
    input logic [`UPIF_ADDR_W-1:0]  up_lbuf_wr_addr,
    input logic [`UPIF_SIZE_W-1:0]  up_lbuf_wr_fsz,
    input logic                     up_lbuf_wr_sob,
    input logic                     up_lbuf_wr_eob,
    input logic [`UPIF_BSZ_W-1:0]   up_lbuf_wr_bsz
);

    localparam int BLK_BEATS = `UPIF_BLK_BYTES / `UPIF_BEAT_BYTES;

    logic [`UPIF_REQ_W-1:0]   exp_req [32];     // requests not yet released
    logic [4:0]               exp_wr;
    logic [4:0]               exp_rd;
    logic [7:0]               gap;              // cycles since last start
    logic                     rdy_d;
    int                       beat_cnt;         // beat index within the file
    int                       cur_idx;
    int                       pos;
    logic [`UPIF_VCH_W+`UPIF_ADDR_W-1:0]  file_fld;
    logic [`UPIF_VCH_W+`UPIF_ADDR_W-1:0]  cur_fld;
    logic [4:0]               ctl_new;          // dvld, sof, eof, sob, eob
    logic [`UPIF_BSZ_W-1:0]   bsz_new;
    logic [4:0]               ctl_d  [2];
    logic [`UPIF_BSZ_W-1:0]   bsz_d  [2];
    logic [`UPIF_DATA_W-1:0]  data_d [2];
    logic [`UPIF_VCH_W+`UPIF_ADDR_W-1:0]  fld_d [2];
    logic [`UPIF_SIZE_W-1:0]  fsz_d  [2];
    int n_rst = 0;
    int n_ord = 0;
    int n_req = 0;
    int n_pace = 0;
    int n_ctl = 0;
    int n_data = 0;
    int n_fld = 0;
    int n_fsz = 0;
    int n_blk = 0;
    int n_bsz = 0;
    int n_rdy = 0;
    int fail_total;

    assign fail_total = n_rst + n_ord + n_req + n_pace + n_ctl + n_data + n_fld + n_fsz
                      + n_blk + n_bsz + n_rdy;

    // ============================================================
    // reference models
    // ============================================================
    always_comb begin
        cur_idx = dma_up_sof ? 0 : beat_cnt;
        pos     = cur_idx % BLK_BEATS;
        cur_fld = dma_up_sof ? {dma_up_vch, dma_up_addr} : file_fld;
        ctl_new = {dma_up_dvld, dma_up_sof, dma_up_eof,
                   dma_up_dvld & (dma_up_sof | (pos == 0)),
                   dma_up_dvld & (dma_up_eof | (pos == BLK_BEATS - 1))};
        bsz_new = dma_up_eof ? `UPIF_BSZ_W'((pos + 1) * `UPIF_BEAT_BYTES)
                             : `UPIF_BSZ_W'(`UPIF_BLK_BYTES);
    end

    always_ff @(posedge USER_CLK or posedge USER_RST) begin
        if (USER_RST) begin
            exp_wr   <= '0;
            exp_rd   <= '0;
            gap      <= 8'hff;
            rdy_d    <= 1'b1;
            beat_cnt <= 0;
            ctl_d[0] <= '0;
            ctl_d[1] <= '0;
        end else begin
            if (up_file_sof) begin
                exp_req[exp_wr] <= {up_file_vch, up_file_addr, up_file_size};
                exp_wr          <= exp_wr + 5'd1;
            end
            if (dma_rd_start) begin
                exp_rd <= exp_rd + 5'd1;
                gap    <= 8'd1;
            end else if (gap != 8'hff) begin
                gap <= gap + 8'd1;
            end
            rdy_d <= up_lbuf_wr_rdy;
            if (dma_up_dvld) begin
                beat_cnt <= cur_idx + 1;
                file_fld <= cur_fld;
            end
            ctl_d[0]  <= ctl_new;
            ctl_d[1]  <= ctl_d[0];
            bsz_d[0]  <= bsz_new;
            bsz_d[1]  <= bsz_d[0];
            data_d[0] <= dma_up_data;
            data_d[1] <= data_d[0];
            fld_d[0]  <= cur_fld;
            fld_d[1]  <= fld_d[0];
            fsz_d[0]  <= dma_up_size;
            fsz_d[1]  <= fsz_d[0];
        end
    end

    // ============================================================
    // request path
    // ============================================================
    a_reset: assert property (@(posedge USER_CLK) USER_RST |-> (!dma_rd_start && !up_lbuf_wr_dvld
            && !up_lbuf_wr_sob && !up_lbuf_wr_eob && dma_up_rdy))
        else begin
            n_rst++;
            $error("outputs not at their reset values during reset");
        end

    a_rd_order: assert property (@(posedge USER_CLK) disable iff (USER_RST)
            dma_rd_start |-> (exp_wr != exp_rd))
        else begin
            n_ord++;
            $error("read start issued with no request pending");
        end

    a_rd_req: assert property (@(posedge USER_CLK) disable iff (USER_RST)
            dma_rd_start |-> ({dma_rd_vch, dma_rd_addr, dma_rd_size} == exp_req[exp_rd]))
        else begin
            n_req++;
            $error("Mismatch dma_rd_vch/addr/size exp %h got %h", exp_req[exp_rd],
                   {dma_rd_vch, dma_rd_addr, dma_rd_size});
        end

    a_rd_pace: assert property (@(posedge USER_CLK) disable iff (USER_RST)
            dma_rd_start |-> (gap >= 8'(`UPIF_RD_PACE)))
        else begin
            n_pace++;
            $error("read starts only %0d cycles apart", gap);
        end

    // ============================================================
    // upload path
    // ============================================================
    a_ctl: assert property (@(posedge USER_CLK) disable iff (USER_RST)
            {up_lbuf_wr_dvld, up_lbuf_wr_sof, up_lbuf_wr_eof} == ctl_d[1][4:2])
        else begin
            n_ctl++;
            $error("Mismatch up_lbuf_wr_dvld/sof/eof exp %h got %h", ctl_d[1][4:2],
                   {up_lbuf_wr_dvld, up_lbuf_wr_sof, up_lbuf_wr_eof});
        end

    a_data: assert property (@(posedge USER_CLK) disable iff (USER_RST)
            ctl_d[1][4] |-> (up_lbuf_wr_data == data_d[1]))
        else begin
            n_data++;
            $error("Mismatch up_lbuf_wr_data exp %h got %h", data_d[1], up_lbuf_wr_data);
        end

    a_fld: assert property (@(posedge USER_CLK) disable iff (USER_RST)
            ctl_d[1][4] |-> ({up_lbuf_wr_vch, up_lbuf_wr_addr} == fld_d[1]))
        else begin
            n_fld++;
            $error("Mismatch up_lbuf_wr_vch/addr exp %h got %h", fld_d[1],
                   {up_lbuf_wr_vch, up_lbuf_wr_addr});
        end

    a_fsz: assert property (@(posedge USER_CLK) disable iff (USER_RST)
            (ctl_d[1][4] && ctl_d[1][2]) |-> (up_lbuf_wr_fsz == fsz_d[1]))
        else begin
            n_fsz++;
            $error("Mismatch up_lbuf_wr_fsz exp %h got %h", fsz_d[1], up_lbuf_wr_fsz);
        end

    a_blk: assert property (@(posedge USER_CLK) disable iff (USER_RST)
            {up_lbuf_wr_sob, up_lbuf_wr_eob} == ctl_d[1][1:0])
        else begin
            n_blk++;
            $error("Mismatch up_lbuf_wr_sob/eob exp %h got %h", ctl_d[1][1:0],
                   {up_lbuf_wr_sob, up_lbuf_wr_eob});
        end

    a_bsz: assert property (@(posedge USER_CLK) disable iff (USER_RST)
            ctl_d[1][0] |-> (up_lbuf_wr_bsz == bsz_d[1]))
        else begin
            n_bsz++;
            $error("Mismatch up_lbuf_wr_bsz exp %h got %h", bsz_d[1], up_lbuf_wr_bsz);
        end

    a_rdy: assert property (@(posedge USER_CLK) disable iff (USER_RST) dma_up_rdy == rdy_d)
        else begin
            n_rdy++;
            $error("Mismatch dma_up_rdy exp %h got %h", rdy_d, dma_up_rdy);
        end

endmodule

// File: dv/upif_tb.sv
// Drives requests and upload files into upif_top; the bound upif_props does the checking.
// Inputs change 1 ns after the rising edge.
`timescale 1ns/1ns
`include "upif_settings.svh"

module upif_tb;

    localparam int N_REQ     = 10;
    localparam int WD_CYCLES = (3 + 512 + 700) + N_REQ * `UPIF_RD_PACE + 1500;

    logic                     USER_CLK = 1'b0;
    logic                     USER_RST = 1'b0;
    logic                     up_file_sof;
    logic [`UPIF_VCH_W-1:0]   up_file_vch;
    logic [`UPIF_ADDR_W-1:0]  up_file_addr;
    logic [`UPIF_SIZE_W-1:0]  up_file_size;
    logic                     dma_rd_start;
    logic [`UPIF_VCH_W-1:0]   dma_rd_vch;
    logic [`UPIF_ADDR_W-1:0]  dma_rd_addr;
    logic [`UPIF_SIZE_W-1:0]  dma_rd_size;
    logic                     dma_up_dvld;
    logic [`UPIF_DATA_W-1:0]  dma_up_data;
    logic                     dma_up_sof;
    logic                     dma_up_eof;
    logic [`UPIF_VCH_W-1:0]   dma_up_vch;
    logic [`UPIF_ADDR_W-1:0]  dma_up_addr;
    logic [`UPIF_SIZE_W-1:0]  dma_up_size;
    logic                     dma_up_rdy;
    logic                     up_lbuf_wr_rdy;
    logic [`UPIF_DATA_W-1:0]  up_lbuf_wr_data;
    logic                     up_lbuf_wr_dvld;
    logic                     up_lbuf_wr_sof;
    logic                     up_lbuf_wr_eof;
    logic [`UPIF_VCH_W-1:0]   up_lbuf_wr_vch;
    logic [`UPIF_ADDR_W-1:0]  up_lbuf_wr_addr;
    logic [`UPIF_SIZE_W-1:0]  up_lbuf_wr_fsz;
    logic                     up_lbuf_wr_sob;
    logic                     up_lbuf_wr_eob;
    logic [`UPIF_BSZ_W-1:0]   up_lbuf_wr_bsz;

    logic [31:0]  lfsr = 32'he10423b9;
    int           rd_starts = 0;
    int           tests_run = 0;
    int           tests_bad = 0;

    always #20 USER_CLK = ~USER_CLK;

    upif_top i_dut (.*);

    bind upif_top upif_props i_props (.*);

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[62:0], lfsr[0]};
        end
    endtask

    task automatic next_cycle();
        @(posedge USER_CLK);
        #1;
    endtask

    task automatic close_test(input string name, input int fails_before);
        int fails;
        fails = i_dut.i_props.fail_total - fails_before;
        tests_run++;
        if (fails != 0) begin
            tests_bad++;
        end
        $display("test %s: %s (%0d assertion failures)", name, (fails == 0) ? "ok" : "bad",
                 fails);
    endtask

    task automatic post_request();
        logic [63:0] v;
        rand_bits(16, v);
        up_file_vch  = v[15:0];
        rand_bits(32, v);
        up_file_addr = v[31:0];
        rand_bits(32, v);
        up_file_size = v[31:0];
        up_file_sof  = 1'b1;
        next_cycle();
        up_file_sof  = 1'b0;
    endtask

    // one file of nb beats, sent only while dma_up_rdy is high
    task automatic send_file(input int nb);
        logic [63:0] v;
        int          n;
        n = 0;
        while (n < nb) begin
            dma_up_dvld = 1'b0;
            dma_up_sof  = 1'b0;
            dma_up_eof  = 1'b0;
            if (dma_up_rdy) begin
                rand_bits(64, v);
                dma_up_data = v;
                dma_up_dvld = 1'b1;
                dma_up_sof  = (n == 0);
                dma_up_eof  = (n == nb - 1);
                rand_bits(16, v);                   // vch and addr count only at sof
                dma_up_vch  = v[15:0];
                rand_bits(32, v);
                dma_up_addr = v[31:0];
                if (n == nb - 1) begin
                    dma_up_size = `UPIF_SIZE_W'(nb * `UPIF_BEAT_BYTES);
                end else begin
                    rand_bits(32, v);               // size counts only at eof
                    dma_up_size = v[31:0];
                end
                n++;
            end
            next_cycle();
        end
        dma_up_dvld = 1'b0;
        dma_up_sof  = 1'b0;
        dma_up_eof  = 1'b0;
        repeat (4) next_cycle();                // 2-cycle path drains
    endtask

    always @(posedge USER_CLK) begin
        if (!USER_RST && dma_rd_start) begin
            rd_starts++;
        end
    end

    // ============================================================
    // watchdog
    // ============================================================
    initial begin
        repeat (WD_CYCLES) @(posedge USER_CLK);
        $display("watchdog expired after %0d cycles, run did not complete", WD_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    // ============================================================
    // tests
    // ============================================================
    initial begin
        int f0;
        up_file_sof    = 1'b0;
        up_file_vch    = '0;
        up_file_addr   = '0;
        up_file_size   = '0;
        dma_up_dvld    = 1'b0;
        dma_up_data    = '0;
        dma_up_sof     = 1'b0;
        dma_up_eof     = 1'b0;
        dma_up_vch     = '0;
        dma_up_addr    = '0;
        dma_up_size    = '0;
        up_lbuf_wr_rdy = 1'b1;

        f0 = i_dut.i_props.fail_total;
        #1;
        USER_RST = 1'b1;                            // async reset before the first edge
        repeat (2) next_cycle();
        USER_RST = 1'b0;
        next_cycle();
        close_test("reset", f0);

        f0 = i_dut.i_props.fail_total;
        for (int b = 0; b < 3; b++) begin           // bursts of 4, 3, 3
            repeat ((b == 0) ? 4 : 3) post_request();
            repeat (12) next_cycle();
        end
        while (rd_starts < N_REQ) begin
            next_cycle();
        end
        repeat (2 * `UPIF_RD_PACE) next_cycle();
        close_test("requests", f0);

        f0 = i_dut.i_props.fail_total;
        send_file(3);
        send_file(512);
        fork
            begin
                repeat (200) next_cycle();
                up_lbuf_wr_rdy = 1'b0;
                repeat (30) next_cycle();
                up_lbuf_wr_rdy = 1'b1;
            end
        join_none
        send_file(700);
        close_test("upload", f0);

        $display("tests %0d, failed %0d, assertion failures %0d", tests_run, tests_bad,
                 i_dut.i_props.fail_total);
        if (tests_bad == 0 && rd_starts == N_REQ) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+include
design/upif_req_pkg.sv
design/upif_stream_pkg.sv
design/upif_req_queue.sv
design/upif_req_dispatch.sv
design/upif_block_seg.sv
design/upif_upload_path.sv
design/upif_top.sv
dv/upif_props.sv
dv/upif_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f flist.f --top-module upif_tb \
    && ./obj_dir/Vupif_tb +verilator+error+limit+1000 | tee /dev/stderr | grep -qx "TB PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
